//--- src.f
design/cache_pkg.sv
design/line_ram.sv
design/valid_store.sv
design/way_match.sv
design/read_port.sv
design/update_pipe.sv
design/cache_top.sv
sim/cache_sva.sv
sim/cache_tb.sv

//--- Bender.yml
package:
  name: cache_store

sources:
  - design/cache_pkg.sv
  - design/line_ram.sv
  - design/valid_store.sv
  - design/way_match.sv
  - design/read_port.sv
  - design/update_pipe.sv
  - design/cache_top.sv
  - target: simulation
    files:
      - sim/cache_sva.sv
      - sim/cache_tb.sv

//--- sim/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

	localparam int SET_W       = 4;
	localparam int SETS        = 2**SET_W;
	// upper bound on the length of the run in cycles
	localparam int TIMEOUT_CYC = 2000;

	logic                  wclk;
	logic                  rst;
	logic                  upd_valid;
	cache_pkg::upd_op_e    upd_op;
	cache_pkg::adr_t       upd_adr;
	cache_pkg::byte_sel_t  upd_sel;
	cache_pkg::line_data_t upd_data;
	logic                  upd_ready;
	logic                  upd_done;
	logic                  upd_hit;
	logic                  rd_valid;
	cache_pkg::adr_t       rd_adr;
	logic                  rd_done;
	logic                  rd_hit;
	logic                  rd_modified;
	cache_pkg::line_data_t rd_data;
	int                    cycles = 0;

	// reference model of the cache indexed by set and way
	cache_pkg::tag_t       m_tag  [SETS][cache_pkg::WAYS];
	cache_pkg::line_data_t m_data [SETS][cache_pkg::WAYS];
	logic                  m_mod  [SETS][cache_pkg::WAYS];
	logic                  m_vld  [SETS][cache_pkg::WAYS];

	cache_top #(.SET_W(SET_W)) UUT (
		.wclk, .rst, .upd_valid, .upd_op, .upd_adr, .upd_sel, .upd_data,
		.upd_ready, .upd_done, .upd_hit,
		.rd_valid, .rd_adr, .rd_done, .rd_hit, .rd_modified, .rd_data
	);

	initial wclk = 1'b0;
	always #4 wclk = ~wclk;

	always @(posedge wclk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Test failed");
			$fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT_CYC);
		end
	end

	// watch the failure count of the bound assertions
	always @(negedge wclk) begin
		if (UUT.u_sva.err_count != 0) begin
			$display("Test failed");
			$fatal(1, "a bound assertion on the port timing failed");
		end
	end

	// ========================================================================
	// checker and reference model
	// ========================================================================
	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// the set index sits directly above the byte offset
	function automatic int set_of(input cache_pkg::adr_t adr);
		return int'(adr[cache_pkg::OFFSET_W +: SET_W]);
	endfunction

	// the tag is the whole line address
	function automatic cache_pkg::tag_t tag_of(input cache_pkg::adr_t adr);
		return adr[cache_pkg::ADR_W-1:cache_pkg::OFFSET_W];
	endfunction

	// lowest valid way holding the tag or -1 on a miss
	function automatic int find_way(input cache_pkg::adr_t adr);
		int s;
		s = set_of(adr);
		for (int w = 0; w < cache_pkg::WAYS; w++) begin
			if (m_vld[s][w] && m_tag[s][w] == tag_of(adr)) begin
				return w;
			end
		end
		return -1;
	endfunction

	task automatic clear_model();
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				m_tag[s][w]  = '0;
				m_data[s][w] = '0;
				m_mod[s][w]  = 1'b0;
				m_vld[s][w]  = 1'b0;
			end
		end
	endtask

	// applies one commit to the model where w is the way found at lookup time
	task automatic model_commit(input cache_pkg::upd_op_e op, input cache_pkg::adr_t adr,
			input cache_pkg::byte_sel_t sel, input cache_pkg::line_data_t data, input int w);
		int s;
		s = set_of(adr);
		if (op == cache_pkg::OP_LOAD) begin
			// older lines move down one way and the last one is lost
			for (int k = cache_pkg::WAYS - 1; k > 0; k--) begin
				m_tag[s][k]  = m_tag[s][k-1];
				m_data[s][k] = m_data[s][k-1];
				m_mod[s][k]  = m_mod[s][k-1];
				m_vld[s][k]  = m_vld[s][k-1];
			end
			m_tag[s][0]  = tag_of(adr);
			m_data[s][0] = data;
			m_mod[s][0]  = 1'b0;
			m_vld[s][0]  = 1'b1;
		end else if (op == cache_pkg::OP_WRITE && w >= 0) begin
			for (int b = 0; b < cache_pkg::BYTES; b++) begin
				if (sel[b]) begin
					m_data[s][w][b*8 +: 8] = data[b*8 +: 8];
				end
			end
			m_mod[s][w] = 1'b1;
		end else if (op == cache_pkg::OP_INVAL && w >= 0) begin
			m_vld[s][w] = 1'b0;
		end
	endtask

	// ========================================================================
	// port drivers
	// ========================================================================
	task automatic do_update(input cache_pkg::upd_op_e op, input cache_pkg::adr_t adr,
			input cache_pkg::byte_sel_t sel, input cache_pkg::line_data_t data);
		int w;
		int k;
		w = find_way(adr);
		@(negedge wclk);
		while (!upd_ready) begin
			@(negedge wclk);
		end
		@(posedge wclk);
		upd_valid <= 1'b1;
		upd_op    <= op;
		upd_adr   <= adr;
		upd_sel   <= sel;
		upd_data  <= data;
		// this edge accepts the operation
		@(posedge wclk);
		upd_valid <= 1'b0;
		@(negedge wclk);
		k = 1;
		while (!upd_done) begin
			@(negedge wclk);
			k++;
		end
		check_value("upd_done latency", k, 3);
		check_value("upd_hit", upd_hit, w >= 0);
		model_commit(op, adr, sel, data, w);
	endtask

	task automatic check_read(input cache_pkg::adr_t adr);
		int w;
		int s;
		w = find_way(adr);
		s = set_of(adr);
		check_value("rd_hit", rd_hit, w >= 0);
		if (w >= 0) begin
			check_value("rd_data", rd_data, m_data[s][w]);
			check_value("rd_modified", rd_modified, m_mod[s][w]);
		end else begin
			// a miss returns all zero
			check_value("rd_data", rd_data, '0);
			check_value("rd_modified", rd_modified, 1'b0);
		end
	endtask

	task automatic do_read(input cache_pkg::adr_t adr);
		int k;
		@(posedge wclk);
		rd_valid <= 1'b1;
		rd_adr   <= adr;
		@(posedge wclk);
		rd_valid <= 1'b0;
		@(negedge wclk);
		k = 1;
		while (!rd_done) begin
			@(negedge wclk);
			k++;
		end
		check_value("rd_done latency", k, 2);
		check_read(adr);
	endtask

	// one request per cycle and request j comes back in loop pass j+2
	task automatic read_burst(input cache_pkg::adr_t adrs [4]);
		for (int j = 0; j < 6; j++) begin
			@(posedge wclk);
			if (j < 4) begin
				rd_valid <= 1'b1;
				rd_adr   <= adrs[j];
			end else begin
				rd_valid <= 1'b0;
			end
			@(negedge wclk);
			check_value("rd_done", rd_done, j >= 2);
			if (j >= 2) begin
				check_read(adrs[j-2]);
			end
		end
	endtask

	function automatic cache_pkg::line_data_t rand_line();
		return {$urandom, $urandom};
	endfunction

	// ========================================================================
	// directed tests
	// ========================================================================
	task automatic test_after_reset();
		do_read(16'h0000);
		do_read(16'h1238);
		do_read(16'hfff8);
		do_read(16'h0a4d);
	endtask

	// a line of set 2 read back at three byte offsets
	task automatic test_load_read();
		do_update(cache_pkg::OP_LOAD, 16'h3410, '0, rand_line());
		do_read(16'h3410);
		do_read(16'h3413);
		do_read(16'h3417);
	endtask

	task automatic test_write_merge();
		do_update(cache_pkg::OP_LOAD, 16'h5a28, '0, rand_line());
		do_update(cache_pkg::OP_WRITE, 16'h5a28, cache_pkg::byte_sel_t'($urandom), rand_line());
		do_read(16'h5a28);
		// the same set with another tag makes the write miss and change nothing
		do_update(cache_pkg::OP_WRITE, 16'h7b28, 8'hff, rand_line());
		do_read(16'h7b28);
		do_read(16'h5a2c);
	endtask

	// five lines of set 11 where the second one is written before the others arrive
	task automatic test_lru_shift();
		cache_pkg::adr_t a [5];
		for (int k = 0; k < 5; k++) begin
			a[k] = 16'h0458 + cache_pkg::adr_t'(k * 16'h0200);
		end
		do_update(cache_pkg::OP_LOAD, a[0], '0, rand_line());
		do_update(cache_pkg::OP_LOAD, a[1], '0, rand_line());
		do_update(cache_pkg::OP_WRITE, a[1], cache_pkg::byte_sel_t'($urandom), rand_line());
		for (int k = 2; k < 5; k++) begin
			do_update(cache_pkg::OP_LOAD, a[k], '0, rand_line());
		end
		for (int k = 0; k < 5; k++) begin
			do_read(a[k]);
		end
	endtask

	// three lines of set 9 with the middle one invalidated
	task automatic test_invalidate();
		do_update(cache_pkg::OP_LOAD, 16'h0c48, '0, rand_line());
		do_update(cache_pkg::OP_LOAD, 16'h0d48, '0, rand_line());
		do_update(cache_pkg::OP_LOAD, 16'h0e48, '0, rand_line());
		do_update(cache_pkg::OP_INVAL, 16'h0d48, '0, '0);
		do_read(16'h0d48);
		do_read(16'h0c48);
		do_read(16'h0e48);
		do_update(cache_pkg::OP_INVAL, 16'h7f48, '0, '0);
		do_read(16'h0c48);
	endtask

	task automatic test_read_burst();
		cache_pkg::adr_t adrs [4];
		adrs[0] = 16'h0c48;
		adrs[1] = 16'h0d48;
		adrs[2] = 16'h0c58;
		adrs[3] = 16'h0458;
		read_burst(adrs);
	endtask

	initial begin
		void'($urandom(32'h77eee83f));
		rst       = 1'b1;
		upd_valid = 1'b0;
		upd_op    = cache_pkg::OP_LOAD;
		upd_adr   = '0;
		upd_sel   = '0;
		upd_data  = '0;
		rd_valid  = 1'b0;
		rd_adr    = '0;
		clear_model();
		repeat (2) @(posedge wclk);
		rst <= 1'b0;
		test_after_reset();
		test_load_read();
		test_write_merge();
		test_lru_shift();
		test_invalidate();
		test_read_burst();
		@(negedge wclk);
		if (UUT.u_sva.err_count != 0) begin
			$display("Test failed");
			$fatal(1, "the bound assertions failed %0d times", UUT.u_sva.err_count);
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/cache_sva.sv
`timescale 1ns/1ps
`default_nettype none

// port timing of the cache store as bound into cache_top
module cache_sva (
	input logic wclk,
	input logic rst,
	input logic upd_valid,
	input logic upd_ready,
	input logic upd_done,
	input logic rd_valid,
	input logic rd_done,
	input logic rd_hit
);

	// number of assertion failures so far
	int err_count = 0;

	// ========================================================================
	// read port with a fixed two cycle latency
	// ========================================================================
	a_rd_follow: assert property (@(posedge wclk) disable iff (rst)
		rd_valid |-> ##2 rd_done)
		else begin
			err_count++;
			$error("rd_done did not follow a read request two cycles later");
		end

	a_rd_source: assert property (@(posedge wclk) disable iff (rst)
		rd_done |-> $past(rd_valid, 2))
		else begin
			err_count++;
			$error("rd_done pulsed with no read request two cycles earlier");
		end

	a_hit_done: assert property (@(posedge wclk) disable iff (rst)
		rd_hit |-> rd_done)
		else begin
			err_count++;
			$error("rd_hit was high outside an rd_done cycle");
		end

	// ========================================================================
	// update port where done comes in the third cycle after acceptance
	// ========================================================================
	a_upd_done: assert property (@(posedge wclk) disable iff (rst)
		upd_valid && upd_ready |=> !upd_done ##1 !upd_done ##1 upd_done ##1 !upd_done)
		else begin
			err_count++;
			$error("upd_done did not pulse once in the third cycle after acceptance");
		end

	a_upd_busy: assert property (@(posedge wclk) disable iff (rst)
		upd_valid && upd_ready |=> !upd_ready [*3] ##1 upd_ready)
		else begin
			err_count++;
			$error("upd_ready was high while an update was in flight");
		end

endmodule

bind cache_top cache_sva u_sva (
	.wclk      (wclk),
	.rst       (rst),
	.upd_valid (upd_valid),
	.upd_ready (upd_ready),
	.upd_done  (upd_done),
	.rd_valid  (rd_valid),
	.rd_done   (rd_done),
	.rd_hit    (rd_hit)
);

`default_nettype wire

//--- design/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

// cache store top, update port and read port on wclk
module cache_top #(
	parameter int SET_W = 4
) (
	input  logic                  wclk,
	input  logic                  rst,
	input  logic                  upd_valid,
	input  cache_pkg::upd_op_e    upd_op,
	input  cache_pkg::adr_t       upd_adr,
	input  cache_pkg::byte_sel_t  upd_sel,
	input  cache_pkg::line_data_t upd_data,
	output logic                  upd_ready,
	output logic                  upd_done,
	output logic                  upd_hit,
	input  logic                  rd_valid,
	input  cache_pkg::adr_t       rd_adr,
	output logic                  rd_done,
	output logic                  rd_hit,
	output logic                  rd_modified,
	output cache_pkg::line_data_t rd_data
);

	logic                 rd_ram_en, up_ram_en, wr_en, val_load;
	logic [SET_W-1:0]     rd_ram_set, up_ram_set, wr_set, rd_vset, up_vset, val_wr_set;
	cache_pkg::set_word_t rd_ram_word, up_ram_word, wr_word;
	cache_pkg::way_mask_t rd_valid_bits, up_valid_bits, val_set_mask, val_clr_mask;

	update_pipe #(.SET_W(SET_W)) u_update (
		.wclk, .rst, .upd_valid, .upd_op, .upd_adr, .upd_sel, .upd_data,
		.upd_ready, .upd_done, .upd_hit,
		.ram_rd_en (up_ram_en), .ram_rd_set (up_ram_set), .ram_word (up_ram_word),
		.ram_wr_en (wr_en), .ram_wr_set (wr_set), .ram_wr_word (wr_word),
		.vset (up_vset), .valid (up_valid_bits),
		.val_load, .val_set_mask, .val_clr_mask, .val_wr_set
	);

	read_port #(.SET_W(SET_W)) u_read (
		.wclk, .rst, .rd_valid, .rd_adr,
		.ram_rd_en (rd_ram_en), .ram_rd_set (rd_ram_set), .ram_word (rd_ram_word),
		.vset (rd_vset), .valid (rd_valid_bits),
		.rd_done, .rd_hit, .rd_modified, .rd_data
	);

	valid_store #(.SET_W(SET_W)) u_valid (
		.wclk, .rst, .rd_set_a (rd_vset), .rd_set_b (up_vset), .val_wr_set,
		.valid_a (rd_valid_bits), .valid_b (up_valid_bits),
		.val_load, .val_set_mask, .val_clr_mask
	);

	// two copies with identical write traffic, one read port each
	line_ram #(.SET_W(SET_W)) u_ram_rd (
		.wclk, .wr_en, .wr_set, .wr_word,
		.rd_en (rd_ram_en), .rd_set (rd_ram_set), .rd_word (rd_ram_word)
	);

	line_ram #(.SET_W(SET_W)) u_ram_upd (
		.wclk, .wr_en, .wr_set, .wr_word,
		.rd_en (up_ram_en), .rd_set (up_ram_set), .rd_word (up_ram_word)
	);

endmodule

`default_nettype wire

//--- design/update_pipe.sv
`timescale 1ns/1ps
`default_nettype none

// ==========================================================================
// update side FSM: IDLE, LOOKUP, MERGE, COMMIT
// ==========================================================================
module update_pipe #(
	parameter int SET_W = 4
) (
	input  logic                  wclk,
	input  logic                  rst,
	input  logic                  upd_valid,
	input  cache_pkg::upd_op_e    upd_op,
	input  cache_pkg::adr_t       upd_adr,
	input  cache_pkg::byte_sel_t  upd_sel,
	input  cache_pkg::line_data_t upd_data,
	output logic                  upd_ready,
	output logic                  upd_done,
	output logic                  upd_hit,
	output logic                  ram_rd_en,
	output logic [SET_W-1:0]      ram_rd_set,
	input  cache_pkg::set_word_t  ram_word,
	output logic                  ram_wr_en,
	output logic [SET_W-1:0]      ram_wr_set,
	output cache_pkg::set_word_t  ram_wr_word,
	output logic [SET_W-1:0]      vset,
	input  cache_pkg::way_mask_t  valid,
	output logic                  val_load,
	output cache_pkg::way_mask_t  val_set_mask,
	output cache_pkg::way_mask_t  val_clr_mask,
	output logic [SET_W-1:0]      val_wr_set
);

	cache_pkg::upd_state_e  state;
	cache_pkg::upd_op_e     op_q;
	cache_pkg::adr_t        adr_q;
	cache_pkg::byte_sel_t   sel_q;
	cache_pkg::line_data_t  data_q;
	logic [SET_W-1:0]       set_q;
	cache_pkg::tag_t        tag_q;
	logic                   accept;
	cache_pkg::way_mask_t   hit_mask;
	cache_pkg::way_mask_t   low_mask;
	logic                   hit;
	cache_pkg::line_data_t  sel_data;
	cache_pkg::line_data_t  wr_data;
	cache_pkg::way_entry_t  load_entry;
	cache_pkg::set_word_t   merged;
	cache_pkg::set_word_t   word_q;
	cache_pkg::way_mask_t   set_mask_q;
	cache_pkg::way_mask_t   clr_mask_q;
	logic                   hit_q;

	assign upd_ready = (state == cache_pkg::IDLE);
	assign accept    = upd_valid && upd_ready;
	assign set_q     = adr_q[cache_pkg::OFFSET_W +: SET_W];
	assign tag_q     = adr_q[cache_pkg::ADR_W-1:cache_pkg::OFFSET_W];

	// the RAM read is launched on the accepting edge so LOOKUP sees the word
	assign ram_rd_en  = accept;
	assign ram_rd_set = upd_adr[cache_pkg::OFFSET_W +: SET_W];
	assign vset       = set_q;

	always_ff @(posedge wclk) begin
		if (rst) begin
			state <= cache_pkg::IDLE;
		end else begin
			case (state)
				cache_pkg::IDLE:   if (upd_valid) state <= cache_pkg::LOOKUP;
				cache_pkg::LOOKUP: state <= cache_pkg::MERGE;
				cache_pkg::MERGE:  state <= cache_pkg::COMMIT;
				default:           state <= cache_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge wclk) begin
		if (accept) begin
			op_q   <= upd_op;
			adr_q  <= upd_adr;
			sel_q  <= upd_sel;
			data_q <= upd_data;
		end
	end

	// LOOKUP compares, the hit mask is ready in MERGE
	way_match u_match (
		.wclk         (wclk),
		.word         (ram_word),
		.valid        (valid),
		.tag          (tag_q),
		.hit_mask     (hit_mask),
		.hit          (hit),
		.sel_data     (sel_data),
		.sel_modified ()
	);

	// isolate the lowest set bit, the way that writes and invalidates act on
	assign low_mask   = hit_mask & (~hit_mask + cache_pkg::way_mask_t'(1));
	assign load_entry = {tag_q, 1'b0, data_q};

	always_comb begin
		for (int b = 0; b < cache_pkg::BYTES; b++) begin
			wr_data[b*8 +: 8] = sel_q[b] ? data_q[b*8 +: 8] : sel_data[b*8 +: 8];
		end
	end

	always_comb begin
		merged = ram_word;
		case (op_q)
			cache_pkg::OP_LOAD: begin
				// LRU shift, old way 3 falls off the top
				merged = {ram_word[(cache_pkg::WAYS-1)*cache_pkg::ENTRY_W-1:0], load_entry};
			end
			cache_pkg::OP_WRITE: begin
				for (int w = 0; w < cache_pkg::WAYS; w++) begin
					if (low_mask[w]) begin
						merged[w*cache_pkg::ENTRY_W +: cache_pkg::DATA_W] = wr_data;
						merged[w*cache_pkg::ENTRY_W + cache_pkg::MOD_BIT] = 1'b1;
					end
				end
			end
			default: begin
				// invalidate rewrites the word as it was
				merged = ram_word;
			end
		endcase
	end

	always_ff @(posedge wclk) begin
		if (state == cache_pkg::MERGE) begin
			word_q     <= merged;
			hit_q      <= hit;
			set_mask_q <= (op_q == cache_pkg::OP_WRITE) ? low_mask : '0;
			clr_mask_q <= (op_q == cache_pkg::OP_INVAL) ? low_mask : '0;
		end
	end

	// COMMIT drives both RAM copies and the valid flops together
	assign upd_done     = (state == cache_pkg::COMMIT);
	assign upd_hit      = upd_done && hit_q;
	assign ram_wr_en    = upd_done && (op_q == cache_pkg::OP_LOAD || hit_q);
	assign ram_wr_set   = set_q;
	assign ram_wr_word  = word_q;
	assign val_wr_set   = set_q;
	assign val_load     = upd_done && (op_q == cache_pkg::OP_LOAD);
	assign val_set_mask = upd_done ? set_mask_q : '0;
	assign val_clr_mask = upd_done ? clr_mask_q : '0;

endmodule

`default_nettype wire

//--- design/read_port.sv
`timescale 1ns/1ps
`default_nettype none

// two stage read pipeline on the read-side RAM copy
module read_port #(
	parameter int SET_W = 4
) (
	input  logic                  wclk,
	input  logic                  rst,
	input  logic                  rd_valid,
	input  cache_pkg::adr_t       rd_adr,
	output logic                  ram_rd_en,
	output logic [SET_W-1:0]      ram_rd_set,
	input  cache_pkg::set_word_t  ram_word,
	output logic [SET_W-1:0]      vset,
	input  cache_pkg::way_mask_t  valid,
	output logic                  rd_done,
	output logic                  rd_hit,
	output logic                  rd_modified,
	output cache_pkg::line_data_t rd_data
);

	logic                 v1;
	logic [SET_W-1:0]     set_q;
	cache_pkg::tag_t      tag_q;
	cache_pkg::way_mask_t valid_g;

	// stage 1, the RAM sees the request set on the same edge as the request
	assign ram_rd_en  = rd_valid;
	assign ram_rd_set = rd_adr[cache_pkg::OFFSET_W +: SET_W];

	always_ff @(posedge wclk) begin
		set_q <= rd_adr[cache_pkg::OFFSET_W +: SET_W];
		tag_q <= rd_adr[cache_pkg::ADR_W-1:cache_pkg::OFFSET_W];
	end

	always_ff @(posedge wclk) begin
		if (rst) begin
			v1      <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			v1      <= rd_valid;
			rd_done <= v1;
		end
	end

	// stage 2, valid bits are looked up for the registered set
	assign vset = set_q;
	// with no request in stage 2 the compare sees no valid way, so the result is all zero
	assign valid_g = valid & {cache_pkg::WAYS{v1}};

	way_match u_match (
		.wclk         (wclk),
		.word         (ram_word),
		.valid        (valid_g),
		.tag          (tag_q),
		.hit_mask     (),
		.hit          (rd_hit),
		.sel_data     (rd_data),
		.sel_modified (rd_modified)
	);

endmodule

`default_nettype wire

//--- design/way_match.sv
`timescale 1ns/1ps
`default_nettype none

// tag compare across all ways of one set word
module way_match (
	input  logic                   wclk,
	input  cache_pkg::set_word_t   word,
	input  cache_pkg::way_mask_t   valid,
	input  cache_pkg::tag_t        tag,
	output cache_pkg::way_mask_t   hit_mask,
	output logic                   hit,
	output cache_pkg::line_data_t  sel_data,
	output logic                   sel_modified
);

	cache_pkg::way_entry_t  ent [cache_pkg::WAYS];
	cache_pkg::way_mask_t   match;
	cache_pkg::line_data_t  data_c;
	logic                   mod_c;

	always_comb begin
		for (int w = 0; w < cache_pkg::WAYS; w++) begin
			ent[w] = word[w*cache_pkg::ENTRY_W +: cache_pkg::ENTRY_W];
			// an invalid way never matches, whatever its stale tag says
			match[w] = valid[w] &&
				(ent[w][cache_pkg::TAG_LSB +: cache_pkg::TAG_W] == tag);
		end
	end

	// walk from the top way down so the lowest matching way wins
	always_comb begin
		data_c = '0;
		mod_c  = 1'b0;
		for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
			if (match[w]) begin
				data_c = ent[w][cache_pkg::DATA_W-1:0];
				mod_c  = ent[w][cache_pkg::MOD_BIT];
			end
		end
	end

	always_ff @(posedge wclk) begin
		hit_mask     <= match;
		hit          <= |match;
		sel_data     <= data_c;
		sel_modified <= mod_c;
	end

endmodule

`default_nettype wire

//--- design/valid_store.sv
`timescale 1ns/1ps
`default_nettype none

// ==========================================================================
// valid bits, one mask per set, kept in flops so reset clears them at once
// ==========================================================================
module valid_store #(
	parameter int SET_W = 4
) (
	input  logic                 wclk,
	input  logic                 rst,
	input  logic [SET_W-1:0]     rd_set_a,
	input  logic [SET_W-1:0]     rd_set_b,
	input  logic [SET_W-1:0]     val_wr_set,
	output cache_pkg::way_mask_t valid_a,
	output cache_pkg::way_mask_t valid_b,
	input  logic                 val_load,
	input  cache_pkg::way_mask_t val_set_mask,
	input  cache_pkg::way_mask_t val_clr_mask
);

	cache_pkg::way_mask_t vmask [2**SET_W];

	// port a serves the read pipeline, port b the update side
	assign valid_a = vmask[rd_set_a];
	assign valid_b = vmask[rd_set_b];

	always_ff @(posedge wclk) begin
		if (rst) begin
			for (int s = 0; s < 2**SET_W; s++) begin
				vmask[s] <= '0;
			end
		end else if (val_load) begin
			// a load pushes the older ways down and way 0 becomes the new line
			vmask[val_wr_set] <= {vmask[val_wr_set][cache_pkg::WAYS-2:0], 1'b1};
		end else if (|val_set_mask || |val_clr_mask) begin
			// write commits set a bit, invalidate commits clear one
			// the two masks are never both nonzero on one commit
			vmask[val_wr_set] <= (vmask[val_wr_set] | val_set_mask) & ~val_clr_mask;
		end
	end

endmodule

`default_nettype wire

//--- design/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

// one word per set, holding every way of that set side by side
module line_ram #(
	parameter int SET_W = 4
) (
	input  logic                 wclk,
	input  logic                 wr_en,
	input  logic [SET_W-1:0]     wr_set,
	input  cache_pkg::set_word_t wr_word,
	input  logic                 rd_en,
	input  logic [SET_W-1:0]     rd_set,
	output cache_pkg::set_word_t rd_word
);

	cache_pkg::set_word_t mem [2**SET_W];

	// simple dual port with one write and one registered read port
	// rd_word holds its value until the next enabled read
	always_ff @(posedge wclk) begin
		if (wr_en) begin
			mem[wr_set] <= wr_word;
		end
		if (rd_en) begin
			rd_word <= mem[rd_set];
		end
	end

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

// ==========================================================================
// shared widths and types of the four-way cache store
// ==========================================================================
package cache_pkg;

	localparam int ADR_W    = 16;
	localparam int DATA_W   = 64;
	localparam int OFFSET_W = 3;
	localparam int WAYS     = 4;
	// the tag is the full line address, so it does not depend on the set count
	localparam int TAG_W    = ADR_W - OFFSET_W;
	localparam int BYTES    = DATA_W / 8;

	// one way entry is laid out as {tag, modified, data}, data lowest
	localparam int ENTRY_W  = TAG_W + 1 + DATA_W;
	localparam int MOD_BIT  = DATA_W;
	localparam int TAG_LSB  = DATA_W + 1;

	typedef logic [ADR_W-1:0]         adr_t;
	typedef logic [TAG_W-1:0]         tag_t;
	typedef logic [DATA_W-1:0]        line_data_t;
	typedef logic [BYTES-1:0]         byte_sel_t;
	typedef logic [WAYS-1:0]          way_mask_t;
	typedef logic [ENTRY_W-1:0]       way_entry_t;
	// way 0 sits in the lowest ENTRY_W bits of a RAM word
	typedef logic [WAYS*ENTRY_W-1:0]  set_word_t;

	typedef enum logic [1:0] {
		OP_LOAD  = 2'd0,
		OP_WRITE = 2'd1,
		OP_INVAL = 2'd2
	} upd_op_e;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		LOOKUP = 2'd1,
		MERGE  = 2'd2,
		COMMIT = 2'd3
	} upd_state_e;

endpackage

`default_nettype wire
